// ==== sim.f ====
source/chipRamPkg.sv
source/refreshTimer.sv
source/dmaAddressLatch.sv
source/requestFifo.sv
source/sdramSequencer.sv
source/chipRamTop.sv
verif/clockGen.sv
verif/sdramModel.sv
verif/chipRamTb.sv

// ==== Makefile ====
# Verilator build and run for the chip RAM controller testbench

VERILATOR ?= verilator
TOP       ?= chipRamTb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
PASS_TEXT ?= All tests passed!

SIM_BIN = $(BUILD_DIR)/V$(TOP)
SOURCES = $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

# The log decides the result, not the simulator exit code
run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) && echo "PASS" || (echo "FAIL, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== verif/chipRamTb.sv ====
module chipRamTb;

    import chipRamPkg::*;

    localparam int fifoDepth        = 4;
    localparam int refreshInterval  = 200;
    localparam int casLatency       = 2;
    localparam int cpuMixedCount    = 200;      // CPU requests beside DMA traffic
    localparam int cpuReadBackCount = 100;      // CPU requests over the DMA region
    // 300 requests at 30 cycles worst case, doubled, plus refresh slack
    localparam int timeoutCycles    = 300 * 30 * 2 + 2000;
    localparam int refreshLimit     = refreshInterval + 40;

    typedef struct {
        chipAddrT            addr;
        logic [dataBits-1:0] data;
    } expectT;

    logic                CAS_AGNUS, nRESET;
    logic                cpuValid, cpuWrite, cpuBurst, cpuCredit;
    chipAddrT            cpuAddr;
    logic [1:0]          cpuMask;
    logic [dataBits-1:0] cpuWdata, dmaWdata;
    logic                dmaRowStrobe, dmaColStrobe, dmaWrite;
    logic [9:0]          dmaBus;
    sdramCmdT            sdramCmd;
    logic [rowBits-1:0]  sdramAddr;
    logic [1:0]          sdramBank;
    logic                sdramCke, sdramDqOe, rdValid, rdSource, initDone;
    logic [dataBits-1:0] sdramDqOut, sdramDqIn, rdData;

    logic [dataBits-1:0] refMem [chipAddrT];  // Reference memory updated in issue order
    expectT              cpuExpect [$];
    expectT              dmaExpect [$];
    int                  cycleCount, credits, creditPending, cpuIssued, creditsReturned;
    int                  dmaTimer, dmaColDelay;
    logic [8:0]          dmaRow;
    string               phase;
    sdramCmdT            initSeq [4] = '{PRECHARGE, MODE, REFRESH, REFRESH};

    clockGen #(.period(4), .resetCycles(8)) u_clockGen (.CAS_AGNUS, .nRESET);

    chipRamTop #(
        .fifoDepth(fifoDepth), .refreshInterval(refreshInterval), .casLatency(casLatency)
    ) u_dut (.*);

    sdramModel u_sdram (
        .CAS_AGNUS, .sdramCmd, .sdramAddr, .sdramCke, .sdramDqOut, .sdramDqOe, .sdramDqIn
    );

    ////////////////////////////////////////////////////////////////////////////
    // Checking
    ////////////////////////////////////////////////////////////////////////////

    task automatic failRun(input string reason);
        $display("%s", reason);
        $display("Test failures found");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic checkValue(input string testName, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (expected !== actual) begin
            failRun($sformatf("CHECK FAILED %s: expected %0h, actual %0h",
                              testName, expected, actual));
        end
    endtask

    function automatic logic [dataBits-1:0] refRead(input chipAddrT addr);
        return refMem.exists(addr) ? refMem[addr] : '0;   // SDRAM model starts at zero
    endfunction

    // Match a returned word against the oldest read of its master
    task automatic collectRead();
        expectT exp;
        if (rdSource == srcDma) begin
            if (dmaExpect.size() == 0) begin
                failRun("DMA read data came back with no DMA read outstanding");
            end else begin
                exp = dmaExpect.pop_front();
                checkValue($sformatf("%s: DMA read at %05h", phase, exp.addr),
                           32'(exp.data), 32'(rdData));
            end
        end else if (cpuExpect.size() == 0) begin
            failRun("CPU read data came back with no CPU read outstanding");
        end else begin
            exp = cpuExpect.pop_front();
            checkValue($sformatf("%s: CPU read at %05h", phase, exp.addr),
                       32'(exp.data), 32'(rdData));
        end
    endtask

    // Outputs are sampled 1 unit after the edge and inputs are driven after that
    task automatic stepCycle();
        credits += creditPending;               // Credit seen last cycle once the queue popped
        if (credits < 0 || credits > fifoDepth) begin
            failRun($sformatf("CPU credit count left its range: %0d", credits));
        end
        @(posedge CAS_AGNUS);
        #1;
        cycleCount++;
        if (cycleCount >= timeoutCycles) begin
            failRun($sformatf("Timed out after %0d cycles waiting on the DUT", cycleCount));
        end
        checkValue("SDRAM bank", 32'd0, 32'(sdramBank));   // Only bank 0 is used
        creditPending    = cpuCredit ? 1 : 0;
        creditsReturned += creditPending;
        if (rdValid) begin
            collectRead();
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////////////////////

    task automatic idleInputs();
        cpuValid     = 1'b0;                    // Strobes last one cycle
        dmaRowStrobe = 1'b0;
        dmaColStrobe = 1'b0;
    endtask

    // CPU region has addr[18] low and columns 252 to 7 so bursts wrap in the row
    task automatic issueCpu(input logic dmaRegion);
        chipAddrT addr, wordAddr;
        expectT   exp;
        int       words;
        if (credits > 0 && $urandom_range(0, 2) == 0) begin
            if (dmaRegion) begin
                addr = {1'b1, 8'($urandom_range(0, 3)), 10'($urandom_range(0, 7))};
            end else begin
                addr = {1'b0, 10'($urandom_range(0, 3)), 8'($urandom_range(0, 11) - 4)};
            end
            cpuValid = 1'b1;
            cpuAddr  = addr;
            cpuWrite = 1'($urandom_range(0, 1));
            cpuBurst = !cpuWrite && ($urandom_range(0, 3) == 0);  // Reads only
            cpuMask  = 2'b11;
            cpuWdata = 16'($urandom);
            credits--;
            cpuIssued++;
            if (cpuWrite) begin
                refMem[addr] = cpuWdata;
            end else begin
                words = cpuBurst ? 4 : 1;
                for (int k = 0; k < words; k++) begin
                    wordAddr = {addr[18:8], addr[7:0] + 8'(k)};   // Next column in the same row
                    exp.addr = wordAddr;
                    exp.data = refRead(wordAddr);
                    cpuExpect.push_back(exp);
                end
            end
        end
    endtask

    // Row strobe then column 1 to 3 cycles later and the next pair 25 or more cycles on
    task automatic driveDma(input logic allowNew);
        chipAddrT addr;
        expectT   exp;
        if (dmaColDelay > 0) begin
            dmaColDelay--;
            if (dmaColDelay == 0) begin
                dmaBus       = 10'($urandom_range(0, 7));
                dmaColStrobe = 1'b1;
                dmaWrite     = 1'($urandom_range(0, 1));
                dmaWdata     = 16'($urandom);
                addr         = {dmaRow, dmaBus};     // Nine row bits over ten column bits
                if (dmaWrite) begin
                    refMem[addr] = dmaWdata;
                end else begin
                    exp.addr = addr;
                    exp.data = refRead(addr);
                    dmaExpect.push_back(exp);
                end
            end
        end else if (dmaTimer > 0) begin
            dmaTimer--;
        end else if (allowNew) begin
            dmaRow       = {1'b1, 8'($urandom_range(0, 3))};    // DMA region has addr[18] high
            dmaBus       = {1'b0, dmaRow};
            dmaRowStrobe = 1'b1;
            dmaColDelay  = $urandom_range(1, 3);
            dmaTimer     = $urandom_range(24, 40);
        end
    endtask

    // Wait for all reads back and for CPU credits to stop arriving
    task automatic drain();
        int quiet;
        quiet = 0;
        while (cpuExpect.size() != 0 || dmaExpect.size() != 0 || quiet < 40) begin
            idleInputs();
            stepCycle();
            quiet = (creditPending != 0) ? 0 : quiet + 1;   // Restart on each returned credit
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        void'($urandom(32'hfdb9));
        cpuValid        = 1'b0;
        cpuAddr         = '0;
        cpuWrite        = 1'b0;
        cpuBurst        = 1'b0;
        cpuMask         = 2'b11;
        cpuWdata        = '0;
        dmaRowStrobe    = 1'b0;
        dmaColStrobe    = 1'b0;
        dmaBus          = '0;
        dmaWrite        = 1'b0;
        dmaWdata        = '0;
        cycleCount      = 0;
        credits         = fifoDepth;
        creditPending   = 0;
        cpuIssued       = 0;
        creditsReturned = 0;
        dmaTimer        = 0;
        dmaColDelay     = 0;
        dmaRow          = '0;

        phase = "reset";
        repeat (4) stepCycle();                 // Still inside reset
        checkValue("reset sdramCmd", 32'(NOP), 32'(sdramCmd));
        checkValue("reset cke, dqOe, credit, rdValid, initDone", 32'd0,
                   32'({sdramCke, sdramDqOe, cpuCredit, rdValid, initDone}));

        // Power-up order, and nothing else before initDone
        phase = "init";
        while (!initDone) stepCycle();
        checkValue("init commands before initDone", 32'd4, 32'(u_sdram.logCount));
        for (int i = 0; i < 4; i++) begin
            checkValue($sformatf("init command %0d", i), 32'(initSeq[i]),
                       32'(u_sdram.cmdLog[i]));
        end

        phase = "mixed CPU and DMA";
        while (cpuIssued < cpuMixedCount || dmaColDelay != 0) begin
            idleInputs();
            if (cpuIssued < cpuMixedCount) begin
                issueCpu(1'b0);
            end
            driveDma(cpuIssued < cpuMixedCount);
            stepCycle();
        end
        drain();

        phase = "CPU reads DMA data";
        while (cpuIssued < cpuMixedCount + cpuReadBackCount) begin
            idleInputs();
            issueCpu(1'b1);
            stepCycle();
        end
        drain();

        checkValue("CPU credits returned", 32'(cpuIssued), 32'(creditsReturned));
        if (u_sdram.refreshCount < 3) begin
            failRun("No periodic refresh reached the SDRAM");
        end else if (u_sdram.maxRefreshGap > refreshLimit) begin
            failRun($sformatf("Refresh gap of %0d cycles is over the %0d cycle limit",
                              u_sdram.maxRefreshGap, refreshLimit));
        end else begin
            $display("All tests passed!");
            $finish;
        end
    end

endmodule

// ==== verif/sdramModel.sv ====
module sdramModel (
    input  logic                            CAS_AGNUS,
    input  chipRamPkg::sdramCmdT            sdramCmd,
    input  logic [chipRamPkg::rowBits-1:0]  sdramAddr,
    input  logic                            sdramCke,
    input  logic [chipRamPkg::dataBits-1:0] sdramDqOut,
    input  logic                            sdramDqOe,
    output logic [chipRamPkg::dataBits-1:0] sdramDqIn
);

    import chipRamPkg::*;

    logic [dataBits-1:0] mem [chipAddrT];      // Unwritten words read as zero
    logic [rowBits-1:0]  openRow;
    logic [2:0]          casLat = 3'd2;        // Until MODE loads the real value
    logic [1:0]          latIdx;
    logic [3:0]          pipeValid = '0;       // Read data on its way to DQ
    logic [dataBits-1:0] pipeData [4];

    // Bookkeeping the testbench looks at
    sdramCmdT            cmdLog [5];           // First five commands other than NOP
    int                  logCount      = 0;
    int                  refreshCount  = 0;
    int                  refreshGap    = 0;    // Cycles since the last REFRESH
    int                  maxRefreshGap = 0;

    function automatic logic [dataBits-1:0] readWord(input chipAddrT addr);
        return mem.exists(addr) ? mem[addr] : '0;
    endfunction

    // Data sits on DQ for the cycle before the CL-th edge after the READ
    assign latIdx    = 2'(casLat - 3'd1);
    assign sdramDqIn = pipeValid[latIdx] ? pipeData[latIdx] : '0;

    always @(posedge CAS_AGNUS) begin
        pipeValid <= {pipeValid[2:0], 1'b0};
        for (int i = 3; i > 0; i--) begin
            pipeData[i] <= pipeData[i-1];
        end
        refreshGap = (sdramCke && sdramCmd == REFRESH) ? 0 : refreshGap + 1;
        if (refreshGap > maxRefreshGap) begin
            maxRefreshGap = refreshGap;
        end
        if (sdramCke && sdramCmd != NOP) begin
            if (logCount < 5) begin
                cmdLog[logCount] = sdramCmd;
                logCount++;
            end
            case (sdramCmd)
                MODE:     casLat  <= sdramAddr[6:4];   // CL field of the mode word
                ACTIVATE: openRow <= sdramAddr;
                REFRESH:  refreshCount++;
                WRITE: begin
                    if (sdramDqOe) begin
                        mem[{openRow, sdramAddr[colBits-1:0]}] = sdramDqOut;
                    end
                end
                READ: begin
                    pipeValid[0] <= 1'b1;
                    pipeData[0]  <= readWord({openRow, sdramAddr[colBits-1:0]});
                end
                default: ;                          // PRECHARGE closes the row, nothing kept
            endcase
        end
    end

endmodule

// ==== verif/clockGen.sv ====
module clockGen #(
    parameter int period      = 4,
    parameter int resetCycles = 8
) (
    output logic CAS_AGNUS,
    output logic nRESET
);

    initial begin
        CAS_AGNUS = 1'b0;
        forever #(period / 2) CAS_AGNUS = ~CAS_AGNUS;   // Free running
    end

    // Reset drops off the edge, like every other driven input
    initial begin
        nRESET = 1'b0;
        repeat (resetCycles) @(posedge CAS_AGNUS);
        #1 nRESET = 1'b1;
    end

endmodule

// ==== source/chipRamTop.sv ====
module chipRamTop #(
    parameter int fifoDepth       = 4,
    parameter int refreshInterval = 200,
    parameter int casLatency      = 2
) (
    input  logic                            CAS_AGNUS,
    input  logic                            nRESET,
    // CPU port
    input  logic                            cpuValid,
    input  chipRamPkg::chipAddrT            cpuAddr,
    input  logic                            cpuWrite,
    input  logic                            cpuBurst,
    input  logic [1:0]                      cpuMask,
    input  logic [chipRamPkg::dataBits-1:0] cpuWdata,
    output logic                            cpuCredit,
    // DMA port, multiplexed address
    input  logic                            dmaRowStrobe,
    input  logic                            dmaColStrobe,
    input  logic [9:0]                      dmaBus,
    input  logic                            dmaWrite,
    input  logic [chipRamPkg::dataBits-1:0] dmaWdata,
    // SDRAM
    output chipRamPkg::sdramCmdT            sdramCmd,
    output logic [chipRamPkg::rowBits-1:0]  sdramAddr,
    output logic [1:0]                      sdramBank,
    output logic                            sdramCke,
    output logic [chipRamPkg::dataBits-1:0] sdramDqOut,
    output logic                            sdramDqOe,
    input  logic [chipRamPkg::dataBits-1:0] sdramDqIn,
    // Read return
    output logic                            rdValid,
    output logic [chipRamPkg::dataBits-1:0] rdData,
    output logic                            rdSource,
    output logic                            initDone
);

    import chipRamPkg::*;

    logic   refreshDue, refreshDone;
    logic   dmaPush, dmaCredit;
    dmaReqT dmaPushData, dmaHead;
    cpuReqT cpuReq, cpuHead;
    logic   cpuQueueValid, dmaQueueValid;
    logic   cpuTake, dmaTake;

    assign cpuReq = '{addr: cpuAddr, write: cpuWrite, burst: cpuBurst,
                      mask: cpuMask, wdata: cpuWdata};

    refreshTimer #(.refreshInterval(refreshInterval)) u_refreshTimer (
        .CAS_AGNUS, .nRESET, .refreshDone, .refreshDue
    );

    dmaAddressLatch #(.fifoDepth(fifoDepth)) u_dmaAddressLatch (
        .CAS_AGNUS, .nRESET, .dmaRowStrobe, .dmaColStrobe, .dmaBus, .dmaWrite, .dmaWdata,
        .pushCredit(dmaCredit), .push(dmaPush), .pushData(dmaPushData)
    );

    requestFifo #(.payloadT(cpuReqT), .fifoDepth(fifoDepth)) u_cpuQueue (
        .CAS_AGNUS, .nRESET, .push(cpuValid), .pushData(cpuReq), .take(cpuTake),
        .valid(cpuQueueValid), .headData(cpuHead), .credit(cpuCredit)
    );

    requestFifo #(.payloadT(dmaReqT), .fifoDepth(fifoDepth)) u_dmaQueue (
        .CAS_AGNUS, .nRESET, .push(dmaPush), .pushData(dmaPushData), .take(dmaTake),
        .valid(dmaQueueValid), .headData(dmaHead), .credit(dmaCredit)
    );

    sdramSequencer #(.casLatency(casLatency)) u_sdramSequencer (
        .CAS_AGNUS, .nRESET, .refreshDue, .refreshDone,
        .cpuValid(cpuQueueValid), .cpuHead, .cpuTake,
        .dmaValid(dmaQueueValid), .dmaHead, .dmaTake,
        .sdramCmd, .sdramAddr, .sdramBank, .sdramCke, .sdramDqOut, .sdramDqOe, .sdramDqIn,
        .rdValid, .rdData, .rdSource, .initDone
    );

endmodule

// ==== source/sdramSequencer.sv ====
module sdramSequencer #(
    parameter int casLatency = 2
) (
    input  logic                            CAS_AGNUS,
    input  logic                            nRESET,
    input  logic                            refreshDue,
    output logic                            refreshDone,
    input  logic                            cpuValid,
    input  chipRamPkg::cpuReqT              cpuHead,
    output logic                            cpuTake,
    input  logic                            dmaValid,
    input  chipRamPkg::dmaReqT              dmaHead,
    output logic                            dmaTake,
    output chipRamPkg::sdramCmdT            sdramCmd,
    output logic [chipRamPkg::rowBits-1:0]  sdramAddr,
    output logic [1:0]                      sdramBank,
    output logic                            sdramCke,
    output logic [chipRamPkg::dataBits-1:0] sdramDqOut,
    output logic                            sdramDqOe,
    input  logic [chipRamPkg::dataBits-1:0] sdramDqIn,
    output logic                            rdValid,
    output logic [chipRamPkg::dataBits-1:0] rdData,
    output logic                            rdSource,
    output logic                            initDone
);

    import chipRamPkg::*;

    typedef enum logic [1:0] {seqIdle, seqRefresh, seqAccess} seqStateT;

    seqStateT            state;
    logic [4:0]          initCnt;               // Power-up step
    logic [3:0]          cycCnt;                // Cycle of access or refresh, plus one
    logic [3:0]          lastColCnt;            // cycCnt of the final column command
    logic [1:0]          wordOff;               // Burst word being addressed
    logic                idleSlot, pickDma, pickCpu;
    logic                colSlot, readSlot;
    logic [casLatency:0] pipeValid;             // Reads in flight
    logic [casLatency:0] pipeSrc;

    // Latched request
    chipAddrT            reqAddr;
    logic                reqWrite, reqBurst, reqSrc;
    logic [dataBits-1:0] reqData;

    ////////////////////////////////////////////////////////////////////////////
    // Arbitration: refresh, then DMA, then CPU
    ////////////////////////////////////////////////////////////////////////////

    assign idleSlot   = initDone && (state == seqIdle) && !refreshDue;
    assign pickDma    = idleSlot && dmaValid;
    assign pickCpu    = idleSlot && !dmaValid && cpuValid;
    assign lastColCnt = (reqBurst && !reqWrite) ? 4'd5 : 4'd2;  // Only reads burst
    assign colSlot    = (state == seqAccess) && (cycCnt >= 4'd2) && (cycCnt <= lastColCnt);
    assign readSlot   = colSlot && !reqWrite;
    assign wordOff    = cycCnt[1:0] - 2'd3;     // First column cycle reads as 3

    always_ff @(posedge CAS_AGNUS) begin
        if (pickDma) begin
            reqAddr  <= dmaHead.addr;
            reqWrite <= dmaHead.write;
            reqBurst <= 1'b0;
            reqData  <= dmaHead.wdata;
            reqSrc   <= srcDma;
        end else if (pickCpu) begin
            reqAddr  <= cpuHead.addr;
            reqWrite <= cpuHead.write;
            reqBurst <= cpuHead.burst;
            reqData  <= cpuHead.wdata;
            reqSrc   <= srcCpu;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Command sequencing
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge CAS_AGNUS or negedge nRESET) begin
        if (!nRESET) begin
            state       <= seqIdle;
            initCnt     <= '0;
            initDone    <= 1'b0;
            cycCnt      <= '0;
            sdramCmd    <= NOP;
            sdramCke    <= 1'b0;
            sdramDqOe   <= 1'b0;
            refreshDone <= 1'b0;
            cpuTake     <= 1'b0;
            dmaTake     <= 1'b0;
        end else begin
            sdramCmd    <= NOP;                 // Single cycle commands
            sdramDqOe   <= 1'b0;
            refreshDone <= 1'b0;
            cpuTake     <= pickCpu;             // Pop lines up with ACTIVATE
            dmaTake     <= pickDma;
            if (!initDone) begin
                initCnt <= initCnt + 1'b1;
                case (initCnt)
                    5'd0:        sdramCke <= 1'b1;
                    5'd1:        sdramCmd <= PRECHARGE;
                    5'd3:        sdramCmd <= MODE;
                    5'd5, 5'd11: sdramCmd <= REFRESH;       // Two to finish power-up
                    5'd17:       initDone <= 1'b1;
                    default:     ;
                endcase
            end else begin
                case (state)
                    seqIdle: begin
                        cycCnt <= 4'd1;
                        if (refreshDue) begin
                            sdramCmd    <= REFRESH;
                            refreshDone <= 1'b1;
                            state       <= seqRefresh;
                        end else if (pickDma || pickCpu) begin
                            sdramCmd <= ACTIVATE;
                            state    <= seqAccess;
                        end
                    end
                    seqRefresh: begin
                        cycCnt <= cycCnt + 1'b1;
                        if (cycCnt == 4'd7) begin
                            state <= seqIdle;           // Eight cycles of tRC
                        end
                    end
                    default: begin
                        cycCnt <= cycCnt + 1'b1;
                        if (colSlot) begin
                            sdramCmd  <= reqWrite ? WRITE : READ;
                            sdramDqOe <= reqWrite;
                        end else if (cycCnt == lastColCnt + 4'd2) begin
                            sdramCmd <= PRECHARGE;
                        end else if (cycCnt == lastColCnt + 4'd4) begin
                            state <= seqIdle;           // Two quiet cycles after PRECHARGE
                        end
                    end
                endcase
            end
        end
    end

    // Address mux follows the command on the pins
    always_comb begin
        case (sdramCmd)
            PRECHARGE:   sdramAddr = 11'b100_0000_0000;            // A10 precharges all
            MODE:        sdramAddr = modeWord(3'(casLatency));
            ACTIVATE:    sdramAddr = rowOf(reqAddr);
            READ, WRITE: sdramAddr = {{(rowBits-colBits){1'b0}}, colOf(reqAddr) + colBits'(wordOff)};
            default:     sdramAddr = '0;
        endcase
    end

    assign sdramBank  = 2'b00;
    assign sdramDqOut = reqData;

    ////////////////////////////////////////////////////////////////////////////
    // Read return
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge CAS_AGNUS or negedge nRESET) begin
        if (!nRESET) begin
            pipeValid <= '0;
            pipeSrc   <= '0;
            rdValid   <= 1'b0;
            rdSource  <= 1'b0;
        end else begin
            pipeValid <= {pipeValid[casLatency-1:0], readSlot};   // Enters with READ
            pipeSrc   <= {pipeSrc[casLatency-1:0], reqSrc};
            rdValid   <= pipeValid[casLatency];                   // CL plus input register
            rdSource  <= pipeSrc[casLatency];
        end
    end

    always_ff @(posedge CAS_AGNUS) begin
        rdData <= sdramDqIn;                    // Input register on DQ
    end

endmodule

// ==== source/requestFifo.sv ====
module requestFifo #(
    parameter type payloadT  = logic,
    parameter int  fifoDepth = 4
) (
    input  logic    CAS_AGNUS,
    input  logic    nRESET,
    input  logic    push,
    input  payloadT pushData,
    input  logic    take,
    output logic    valid,
    output payloadT headData,
    output logic    credit
);

    localparam int ptrBits = (fifoDepth > 1) ? $clog2(fifoDepth) : 1;

    payloadT            mem [fifoDepth];
    logic [ptrBits-1:0] wrPtr;
    logic [ptrBits-1:0] rdPtr;
    logic [ptrBits:0]   count;                  // Entries held

    // Wrap for any depth, not only powers of two
    function automatic logic [ptrBits-1:0] nextPtr(input logic [ptrBits-1:0] ptr);
        return (ptr == ptrBits'(fifoDepth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign valid    = (count != '0);
    assign headData = mem[rdPtr];               // Head shows without an extra cycle
    assign credit   = take && valid;            // One credit back per entry taken

    always_ff @(posedge CAS_AGNUS or negedge nRESET) begin
        if (!nRESET) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wrPtr <= nextPtr(wrPtr);
            end
            if (take) begin
                rdPtr <= nextPtr(rdPtr);
            end
            count <= count + (ptrBits+1)'(push) - (ptrBits+1)'(take);
        end
    end

    always_ff @(posedge CAS_AGNUS) begin
        if (push) begin
            mem[wrPtr] <= pushData;
        end
    end

    // Credits on the write side keep these from ever firing
    noPushWhenFull: assert property (
        @(posedge CAS_AGNUS) disable iff (!nRESET)
        push |-> (count < (ptrBits+1)'(fifoDepth))
    ) else $error("Push into a full request queue");

    noTakeWhenEmpty: assert property (
        @(posedge CAS_AGNUS) disable iff (!nRESET)
        take |-> valid
    ) else $error("Take from an empty request queue");

endmodule

// ==== source/dmaAddressLatch.sv ====
module dmaAddressLatch #(
    parameter int fifoDepth = 4
) (
    input  logic                          CAS_AGNUS,
    input  logic                          nRESET,
    input  logic                          dmaRowStrobe,
    input  logic                          dmaColStrobe,
    input  logic [9:0]                    dmaBus,
    input  logic                          dmaWrite,
    input  logic [chipRamPkg::dataBits-1:0] dmaWdata,
    input  logic                          pushCredit,
    output logic                          push,
    output chipRamPkg::dmaReqT            pushData
);

    import chipRamPkg::*;

    localparam int credBits = $clog2(fifoDepth + 1);

    logic [8:0]          rowLatch;               // Top row bit is not mapped
    logic                rowSeen;                // Row strobe since last column strobe
    logic [credBits-1:0] credits;                // Free slots in the DMA queue

    always_ff @(posedge CAS_AGNUS or negedge nRESET) begin
        if (!nRESET) begin
            push    <= 1'b0;
            rowSeen <= 1'b0;
            credits <= credBits'(fifoDepth);
        end else begin
            push    <= dmaColStrobe;            // Request goes out one cycle after CAS
            credits <= credits - credBits'(push) + credBits'(pushCredit);
            if (dmaRowStrobe) begin
                rowSeen <= 1'b1;
            end else if (dmaColStrobe) begin
                rowSeen <= 1'b0;                // Next column needs a fresh row
            end
        end
    end

    // Address and data capture
    always_ff @(posedge CAS_AGNUS) begin
        if (dmaRowStrobe) begin
            rowLatch <= dmaBus[8:0];
        end
        if (dmaColStrobe) begin
            pushData.addr  <= dmaAddr(rowLatch, dmaBus);
            pushData.write <= dmaWrite;
            pushData.wdata <= dmaWdata;
        end
    end

    // DMA engine cannot be stalled, so the queue must always have room
    pushHasCredit: assert property (
        @(posedge CAS_AGNUS) disable iff (!nRESET)
        push |-> (credits != '0)
    ) else $error("DMA push with no queue credit");

    colAfterRow: assert property (
        @(posedge CAS_AGNUS) disable iff (!nRESET)
        dmaColStrobe |-> rowSeen
    ) else $error("DMA column strobe without row strobe");

endmodule

// ==== source/refreshTimer.sv ====
module refreshTimer #(
    parameter int refreshInterval = 200
) (
    input  logic CAS_AGNUS,
    input  logic nRESET,
    input  logic refreshDone,
    output logic refreshDue
);

    localparam int cntBits = $clog2(refreshInterval + 1);

    logic [cntBits-1:0] clkCnt;                 // Clocks since last REFRESH

    always_ff @(posedge CAS_AGNUS or negedge nRESET) begin
        if (!nRESET) begin
            clkCnt     <= '0;
            refreshDue <= 1'b0;
        end else if (refreshDone) begin
            clkCnt     <= '0;                   // Restart the interval
            refreshDue <= 1'b0;
        end else if (!refreshDue) begin
            clkCnt <= clkCnt + 1'b1;
            if (clkCnt == cntBits'(refreshInterval - 1)) begin
                refreshDue <= 1'b1;             // Held until the sequencer gets to it
            end
        end
    end

    // Sequencer only refreshes on request once init is over
    refreshOnlyWhenDue: assert property (
        @(posedge CAS_AGNUS) disable iff (!nRESET)
        refreshDone |-> refreshDue
    ) else $error("refreshDone without refreshDue");

endmodule

// ==== source/chipRamPkg.sv ====
package chipRamPkg;

    ////////////////////////////////////////////////////////////////////////////
    // Widths
    ////////////////////////////////////////////////////////////////////////////

    localparam int rowBits  = 11;                 // SDRAM row, also address bus width
    localparam int colBits  = 8;                  // SDRAM column within bank 0
    localparam int dataBits = 16;                 // One chip RAM word

    // Encoded as {nCS, nRAS, nCAS, nWE}
    typedef enum logic [3:0] {
        NOP       = 4'b1111,
        PRECHARGE = 4'b0010,
        ACTIVATE  = 4'b0011,
        READ      = 4'b0101,
        WRITE     = 4'b0100,
        REFRESH   = 4'b0001,
        MODE      = 4'b0000
    } sdramCmdT;

    typedef logic [rowBits+colBits-1:0] chipAddrT; // Word address, row on top

    typedef struct packed {
        chipAddrT            addr;
        logic                write;
        logic                burst;                // Four word read
        logic [1:0]          mask;                 // Upper and lower byte
        logic [dataBits-1:0] wdata;
    } cpuReqT;

    typedef struct packed {
        chipAddrT            addr;
        logic                write;
        logic [dataBits-1:0] wdata;
    } dmaReqT;

    // Source tag on returned reads
    localparam logic srcCpu = 1'b0;
    localparam logic srcDma = 1'b1;

    // Burst length 1, sequential, CAS latency in A6..A4
    function automatic logic [rowBits-1:0] modeWord(input logic [2:0] cl);
        return {4'b0000, cl, 4'b0000};
    endfunction

    function automatic logic [rowBits-1:0] rowOf(input chipAddrT addr);
        return addr[rowBits+colBits-1:colBits];
    endfunction

    function automatic logic [colBits-1:0] colOf(input chipAddrT addr);
        return addr[colBits-1:0];
    endfunction

    // DMA address from nine row bits and ten column bits
    function automatic chipAddrT dmaAddr(input logic [8:0] row, input logic [9:0] col);
        return {row, col};
    endfunction

endpackage
